/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_frontend -o tb_frontend
out=$(./obj_dir/tb_frontend)
echo "$out"

if echo "$out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1

/* sim/frontend_checker.sv */
`timescale 1ns/1ns

module frontend_checker import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        imem_en_i,
    input  inst_t [1:0] inst_i,
    input  logic [1:0]  inst_valid_i,
    input  logic [1:0]  issue_num_i,
    input  logic        backend_stall_i,
    output int          consumed_o,
    output logic        done_o,
    output int          pass_count_o,
    output int          fail_count_o
);

    localparam int GOLD_WORDS = 384;
    // five words per expected entry
    localparam int EXP_BASE   = 'h30;

    logic [31:0] gold [GOLD_WORDS];
    int          n_exp;
    int          since_reset;
    logic        reset_ok;

    initial begin
        $readmemh("sim/frontend_golden.txt", gold);
        n_exp        = int'(gold[1]);
        consumed_o   = 0;
        done_o       = 1'b0;
        pass_count_o = 0;
        fail_count_o = 0;
        since_reset  = 0;
        reset_ok     = 1'b1;
    end

    function automatic logic field_matches(input string name, input logic [31:0] exp,
                                           input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // idle cycle first, then the first request
    task automatic check_reset_cycle(input int cyc);
        logic want_en;
        want_en = (cyc == 1);
        reset_ok = field_matches("imem_en_o", 32'(want_en), 32'(imem_en_i)) & reset_ok;
        reset_ok = field_matches("inst_valid_o", 32'd0, 32'(inst_valid_i)) & reset_ok;
        if (cyc == 1) begin
            if (reset_ok) begin
                pass_count_o++;
                $display("reset: ok");
            end else begin
                fail_count_o++;
                $display("reset: mismatch");
            end
        end
    endtask

    task automatic check_slot(input int slot);
        int    base;
        logic  ok;
        inst_t act;
        act  = inst_i[slot];
        base = EXP_BASE + 5 * consumed_o;
        ok   = 1'b1;
        ok = field_matches($sformatf("inst_o[%0d].pc", slot), gold[base], act.pc) & ok;
        ok = field_matches($sformatf("inst_o[%0d].w_reg", slot), gold[base + 1],
                           32'(act.register_info.w_reg)) & ok;
        ok = field_matches($sformatf("inst_o[%0d].r_reg[0]", slot), gold[base + 2],
                           32'(act.register_info.r_reg[0])) & ok;
        ok = field_matches($sformatf("inst_o[%0d].r_reg[1]", slot), gold[base + 3],
                           32'(act.register_info.r_reg[1])) & ok;
        ok = field_matches($sformatf("inst_o[%0d].illegal", slot), gold[base + 4],
                           32'(act.decode_info.illegal)) & ok;
        if (ok) begin
            pass_count_o++;
            $display("entry %0d pc %h: ok", consumed_o, act.pc);
        end else begin
            fail_count_o++;
            $display("entry %0d pc %h: mismatch", consumed_o, act.pc);
        end
        consumed_o++;
    endtask

    // slots seen here are taken at the next rising edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            since_reset = 0;
        end else begin
            if (since_reset < 2) begin
                check_reset_cycle(since_reset);
            end
            since_reset++;
            if (!backend_stall_i) begin
                for (int s = 0; s < int'(issue_num_i); s++) begin
                    check_slot(s);
                end
            end
            if (consumed_o >= n_exp) begin
                done_o = 1'b1;
            end
        end
    end

endmodule

/* sim/frontend_golden.txt */
// @00 redirect count, expected count; @08 image; @28 redirects as consumed count, target pc
// @30 expected entries as pc, write reg, read reg 0, read reg 1, illegal, two per line
@00
00000003 0000001e
@08
142468a4 02804085 00101486 001114c7 00150ce8 58001109 54000400 deadbeef
5c00214b 50000800 0280056c 0010058d 1400002e 00000000 001535cf 001109f0
58004211 029ffe32 54001000 00104653 15fffff4 5c008293 00154e95 001152b6
50000400 ffffffff 02800ad7 00105af8 14015799 58001338 54000800 0015633a
@28
0000000a 1c000050 0000000e 1c00002c 00000017 1c000064
@30
1c000000 04 00 00 0 1c000004 05 00 04 0
1c000008 06 05 04 0 1c00000c 07 05 06 0
1c000010 08 03 07 0 1c000014 00 09 08 0
1c000018 01 00 00 0 1c00001c 00 00 00 1
1c000020 00 0b 0a 0 1c000024 00 00 00 0
1c000050 14 00 00 0 1c000054 00 13 14 0
1c000058 15 13 14 0 1c00005c 16 14 15 0
1c00002c 0d 01 0c 0 1c000030 0e 00 00 0
1c000034 00 00 00 1 1c000038 0f 0d 0e 0
1c00003c 10 02 0f 0 1c000040 00 11 10 0
1c000044 12 00 11 0 1c000048 01 00 00 0
1c00004c 13 11 12 0 1c000064 00 00 00 1
1c000068 17 00 16 0 1c00006c 18 16 17 0
1c000070 19 00 00 0 1c000074 00 18 19 0
1c000078 01 00 00 0 1c00007c 1a 18 19 0

/* sim/tb_frontend.sv */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module tb_frontend
    import pipe_pkg::*;
();

    // golden file layout, word addresses
    localparam int GOLD_WORDS = 384;
    localparam int IMG_BASE   = 'h08;
    localparam int REDIR_BASE = 'h28;

    logic                      clk;
    logic                      rst_n_i;
    logic                      imem_en_o;
    logic [`FE_ADDR_WIDTH-1:0] imem_addr_o;
    logic [63:0]               imem_rdata_i;
    logic                      redirect_i;
    logic [`FE_ADDR_WIDTH-1:0] redirect_pc_i;
    inst_t [1:0]               inst_o;
    logic [1:0]                inst_valid_o;
    logic [1:0]                issue_num_i;
    logic                      backend_stall_i;

    logic [31:0] gold [GOLD_WORDS];
    logic [31:0] rng;
    logic        req_en;
    logic [31:0] req_addr;
    int          n_redir;
    int          n_exp;
    int          ev;
    int          consumed;
    int          pass_count;
    int          fail_count;
    logic        done;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    frontend uut (
        .clk,
        .rst_n_i,
        .imem_en_o,
        .imem_addr_o,
        .imem_rdata_i,
        .redirect_i,
        .redirect_pc_i,
        .inst_o,
        .inst_valid_o,
        .issue_num_i,
        .backend_stall_i
    );

    frontend_checker checker_u (
        .clk,
        .rst_n_i,
        .imem_en_i       (imem_en_o),
        .inst_i          (inst_o),
        .inst_valid_i    (inst_valid_o),
        .issue_num_i,
        .backend_stall_i,
        .consumed_o      (consumed),
        .done_o          (done),
        .pass_count_o    (pass_count),
        .fail_count_o    (fail_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // outside the image the word is derived from its address
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `FE_RESET_PC;
        if (off < 32'd128) begin
            return gold[IMG_BASE + int'(off[6:2])];
        end
        return addr ^ 32'h5a5a5a5a;
    endfunction

    // memory model, one cycle read latency
    always @(negedge clk) begin
        req_en   = imem_en_o;
        req_addr = imem_addr_o;
    end

    always @(posedge clk) begin
        #1;
        if (req_en) begin
            imem_rdata_i = {image_word(req_addr + 32'd4), image_word(req_addr)};
        end
    end

    task automatic step_backend();
        int valid_cnt;
        int limit;
        int want;
        valid_cnt = int'(inst_valid_o[0]) + int'(inst_valid_o[1]);
        if (ev < n_redir && consumed == int'(gold[REDIR_BASE + 2 * ev])) begin
            redirect_i      = 1'b1;
            redirect_pc_i   = gold[REDIR_BASE + 2 * ev + 1];
            issue_num_i     = 2'd0;
            backend_stall_i = 1'b0;
            ev++;
        end else begin
            redirect_i = 1'b0;
            rng        = xorshift32(rng);
            // never run past the next redirect point
            if (ev < n_redir) begin
                limit = int'(gold[REDIR_BASE + 2 * ev]) - consumed;
            end else begin
                limit = n_exp - consumed;
            end
            want = int'(rng[5:4]) % 3;
            if (want > valid_cnt) begin
                want = valid_cnt;
            end
            if (want > limit) begin
                want = limit;
            end
            backend_stall_i = (rng[2:0] == 3'd0);
            issue_num_i     = 2'(want);
        end
    endtask

    initial begin
        rst_n_i         = 1'b0;
        imem_rdata_i    = 64'd0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        issue_num_i     = 2'd0;
        backend_stall_i = 1'b0;
        req_en          = 1'b0;
        req_addr        = '0;
        rng             = 32'h9c174114;
        ev              = 0;
        $readmemh("sim/frontend_golden.txt", gold);
        n_redir = int'(gold[0]);
        n_exp   = int'(gold[1]);
        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;
        while (!done) begin
            @(posedge clk);
            #1;
            step_backend();
        end
        repeat (4) @(posedge clk);
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog, 40 cycles per expected instruction
    initial begin
        #1;
        repeat (40 * n_exp) @(posedge clk);
        $display("timeout: only %0d of %0d instructions consumed after %0d cycles",
                 consumed, n_exp, 40 * n_exp);
        $display("summary: %0d passed, %0d failed", pass_count, fail_count + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/npc.sv
verilog/fetch_stage.sv
verilog/multi_channel_fifo.sv
verilog/decoder.sv
verilog/frontend.sv
sim/frontend_checker.sv
sim/tb_frontend.sv

/* verilog/decoder.sv */
`timescale 1ns/1ns

module decoder import isa_pkg::*; (
    input  logic [31:0]    inst_i,
    output decode_info_t   decode_info_o,
    output register_info_t register_info_o
);

    logic [16:0] op_31_15;
    logic [9:0]  op_31_22;
    logic [6:0]  op_31_25;
    logic [5:0]  op_31_26;

    assign op_31_15 = inst_i[31:15];
    assign op_31_22 = inst_i[31:22];
    assign op_31_25 = inst_i[31:25];
    assign op_31_26 = inst_i[31:26];

    always_comb begin
        decode_info_o.reg_type  = NONE;
        decode_info_o.is_branch = 1'b0;
        decode_info_o.illegal   = 1'b0;
        decode_info_o.inst25_0  = inst_i[25:0];
        // add.w, sub.w, or
        if (op_31_15 == 17'h00020 || op_31_15 == 17'h00022 || op_31_15 == 17'h0002a) begin
            decode_info_o.reg_type = RRW;
        end else if (op_31_22 == 10'b0000001010) begin
            decode_info_o.reg_type = RW;   // addi.w
        end else if (op_31_25 == 7'b0001010) begin
            decode_info_o.reg_type = W;    // lu12i.w
        end else if (op_31_26 == 6'b010110 || op_31_26 == 6'b010111) begin
            decode_info_o.reg_type  = RR;
            decode_info_o.is_branch = 1'b1;
        end else if (op_31_26 == 6'b010101) begin
            decode_info_o.reg_type  = BL;
            decode_info_o.is_branch = 1'b1;
        end else if (op_31_26 == 6'b010100) begin
            decode_info_o.is_branch = 1'b1;
        end else begin
            decode_info_o.illegal = 1'b1;
        end
    end

    // register fields by class
    always_comb begin
        register_info_o = '0;
        case (decode_info_o.reg_type)
            RRW: begin
                register_info_o.r_reg[0] = inst_i[14:10];
                register_info_o.r_reg[1] = inst_i[9:5];
                register_info_o.w_reg    = inst_i[4:0];
            end
            RW: begin
                register_info_o.r_reg[1] = inst_i[9:5];
                register_info_o.w_reg    = inst_i[4:0];
            end
            W: begin
                register_info_o.w_reg = inst_i[4:0];
            end
            RR: begin
                register_info_o.r_reg[0] = inst_i[4:0];
                register_info_o.r_reg[1] = inst_i[9:5];
            end
            BL: begin
                register_info_o.w_reg = 5'd1;  // return address in r1
            end
            default: begin
                register_info_o = '0;
            end
        endcase
    end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module fetch_stage import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [`FE_ADDR_WIDTH-1:0] pc_i,
    input  logic                      pc_valid_i,
    input  logic                      redirect_i,
    input  logic [`FE_ADDR_WIDTH-1:0] redirect_pc_i,
    input  logic [63:0]               imem_rdata_i,
    output logic                      imem_en_o,
    output logic [`FE_ADDR_WIDTH-1:0] imem_addr_o,
    output fetch_entry_t [1:0]        entry_o,
    output logic [1:0]                write_num_o
);

    logic                      req_valid_q;
    logic [`FE_ADDR_WIDTH-1:0] req_pc_q;
    logic                      req_lo_valid_q;
    logic                      skip_lo_q;
    logic [`FE_ADDR_WIDTH-1:0] pc_hi;

    // no request leaves in a redirect cycle
    assign imem_en_o   = pc_valid_i & ~redirect_i;
    assign imem_addr_o = pc_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_valid_q <= 1'b0;
            skip_lo_q   <= 1'b0;
        end else begin
            req_valid_q <= imem_en_o;
            // low word skipped on the first fetch after a redirect to pc+4
            if (redirect_i) begin
                skip_lo_q <= redirect_pc_i[2];
            end else if (imem_en_o) begin
                skip_lo_q <= 1'b0;
            end
        end
    end

    // high slot of a fetch is always valid
    always_ff @(posedge clk) begin
        if (imem_en_o) begin
            req_pc_q       <= pc_i;
            req_lo_valid_q <= ~skip_lo_q;
        end
    end

    assign pc_hi = req_pc_q + `FE_ADDR_WIDTH'(4);

    // pack valid slots from slot 0 upward
    always_comb begin
        entry_o[0].pc   = req_lo_valid_q ? req_pc_q : pc_hi;
        entry_o[0].inst = req_lo_valid_q ? imem_rdata_i[31:0] : imem_rdata_i[63:32];
        entry_o[1].pc   = pc_hi;
        entry_o[1].inst = imem_rdata_i[63:32];
        if (req_valid_q && !redirect_i) begin
            write_num_o = req_lo_valid_q ? 2'd2 : 2'd1;
        end else begin
            write_num_o = 2'd0;
        end
    end

endmodule

/* verilog/frontend.sv */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module frontend import isa_pkg::*, pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,

    output logic                      imem_en_o,
    output logic [`FE_ADDR_WIDTH-1:0] imem_addr_o,
    input  logic [63:0]               imem_rdata_i,

    input  logic                      redirect_i,
    input  logic [`FE_ADDR_WIDTH-1:0] redirect_pc_i,

    output inst_t [1:0]               inst_o,
    output logic [1:0]                inst_valid_o,
    input  logic [1:0]                issue_num_i,
    input  logic                      backend_stall_i
);

    logic [`FE_ADDR_WIDTH-1:0] npc_pc;
    logic                      npc_pc_valid;
    logic                      raw_write_ready;
    fetch_entry_t [1:0]        fetch_entry;
    logic [1:0]                fetch_write_num;
    logic [1:0]                raw_valid;
    fetch_entry_t [1:0]        raw_entry;
    decode_info_t [1:0]        dec_info;
    register_info_t [1:0]      reg_info;
    inst_t [1:0]               dec_inst;
    logic [1:0]                dec_write_num;
    logic                      dec_write_ready;

    npc npc_u (
        .clk,
        .rst_n_i,
        .stall_i    (~raw_write_ready),
        .redirect_i,
        .redirect_pc_i,
        .pc_o       (npc_pc),
        .pc_valid_o (npc_pc_valid)
    );

    fetch_stage fetch_u (
        .clk,
        .rst_n_i,
        .pc_i        (npc_pc),
        .pc_valid_i  (npc_pc_valid),
        .redirect_i,
        .redirect_pc_i,
        .imem_rdata_i,
        .imem_en_o,
        .imem_addr_o,
        .entry_o     (fetch_entry),
        .write_num_o (fetch_write_num)
    );

    multi_channel_fifo #(
        .payload_t (fetch_entry_t),
        .DEPTH     (`FE_RAW_DEPTH),
        .PORTS     (`FE_FETCH_WIDTH)
    ) raw_queue (
        .clk,
        .rst_n_i,
        .flush_i       (redirect_i),
        .write_num_i   (fetch_write_num),
        .write_data_i  (fetch_entry),
        .write_ready_o (raw_write_ready),
        .read_valid_o  (raw_valid),
        .read_ready_i  (dec_write_ready),
        .read_num_i    (dec_write_num),
        .read_data_o   (raw_entry)
    );

    for (genvar i = 0; i < `FE_FETCH_WIDTH; i++) begin : g_dec
        decoder decoder_u (
            .inst_i          (raw_entry[i].inst),
            .decode_info_o   (dec_info[i]),
            .register_info_o (reg_info[i])
        );

        assign dec_inst[i].pc            = raw_entry[i].pc;
        assign dec_inst[i].inst          = raw_entry[i].inst;
        assign dec_inst[i].decode_info   = dec_info[i];
        assign dec_inst[i].register_info = reg_info[i];
    end

    // move whatever the raw queue offers once the decoded queue has room
    always_comb begin
        if (!dec_write_ready) begin
            dec_write_num = 2'd0;
        end else if (raw_valid[1]) begin
            dec_write_num = 2'd2;
        end else begin
            dec_write_num = {1'b0, raw_valid[0]};
        end
    end

    multi_channel_fifo #(
        .payload_t (inst_t),
        .DEPTH     (`FE_DEC_DEPTH),
        .PORTS     (`FE_FETCH_WIDTH)
    ) dec_queue (
        .clk,
        .rst_n_i,
        .flush_i       (redirect_i),
        .write_num_i   (dec_write_num),
        .write_data_i  (dec_inst),
        .write_ready_o (dec_write_ready),
        .read_valid_o  (inst_valid_o),
        .read_ready_i  (~backend_stall_i),
        .read_num_i    (issue_num_i),
        .read_data_o   (inst_o)
    );

endmodule

/* verilog/frontend_macros.svh */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// instructions delivered per fetch
`define FE_FETCH_WIDTH 2

// queue depths, both a power of two
`define FE_RAW_DEPTH 8
`define FE_DEC_DEPTH 4

// fetch address width
`define FE_ADDR_WIDTH 32

// first fetch address after reset
`define FE_RESET_PC 32'h1c000000

`endif

/* verilog/isa_pkg.sv */
package isa_pkg;

    // register usage class of one instruction
    typedef enum logic [3:0] {
        NONE = 4'd0,
        RW   = 4'd1,
        RRW  = 4'd2,
        W    = 4'd3,
        RR   = 4'd4,
        BL   = 4'd5
    } reg_type_e;

    typedef struct packed {
        reg_type_e   reg_type;
        logic        is_branch;
        logic        illegal;
        // low instruction bits, register fields live here
        logic [25:0] inst25_0;
    } decode_info_t;

    // zero register number means unused
    typedef struct packed {
        logic [1:0][4:0] r_reg;
        logic [4:0]      w_reg;
    } register_info_t;

endpackage

/* verilog/multi_channel_fifo.sv */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module multi_channel_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8,
    parameter int  PORTS     = `FE_FETCH_WIDTH,
    localparam int NW        = $clog2(PORTS + 1)
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic [NW-1:0]        write_num_i,
    input  payload_t [PORTS-1:0] write_data_i,
    output logic                 write_ready_o,

    output logic [PORTS-1:0]     read_valid_o,
    input  logic                 read_ready_i,
    input  logic [NW-1:0]        read_num_i,
    output payload_t [PORTS-1:0] read_data_o
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   head_q;
    logic [PW-1:0]   tail_q;
    logic [CW-1:0]   count_q;
    logic [CW-1:0]   wr_cnt;
    logic [CW-1:0]   rd_cnt;
    logic [CW-1:0]   free_cnt;

    assign wr_cnt   = CW'(write_num_i);
    assign rd_cnt   = read_ready_i ? CW'(read_num_i) : '0;
    assign free_cnt = CW'(DEPTH) - count_q;

    // room for one more response already in flight
    assign write_ready_o = free_cnt >= CW'(2 * PORTS);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PW'(rd_cnt);
            tail_q  <= tail_q + PW'(wr_cnt);
            count_q <= count_q + wr_cnt - rd_cnt;
        end
    end

    // pointers wrap by width, depth is a power of two
    always_ff @(posedge clk) begin
        for (int i = 0; i < PORTS; i++) begin
            if (NW'(i) < write_num_i) begin
                mem[tail_q + PW'(i)] <= write_data_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < PORTS; i++) begin
            read_valid_o[i] = count_q > CW'(i);
            read_data_o[i]  = mem[head_q + PW'(i)];
        end
    end

endmodule

/* verilog/npc.sv */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module npc (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      redirect_i,
    input  logic [`FE_ADDR_WIDTH-1:0] redirect_pc_i,
    output logic [`FE_ADDR_WIDTH-1:0] pc_o,
    output logic                      pc_valid_o
);

    logic [`FE_ADDR_WIDTH-1:0] pc_q;
    logic                      started_q;

    // one idle cycle after reset before the first request
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect_i) begin
            // fetch is always 8-byte aligned
            pc_q <= {redirect_pc_i[`FE_ADDR_WIDTH-1:3], 3'b000};
        end else if (started_q && !stall_i) begin
            pc_q <= pc_q + `FE_ADDR_WIDTH'(8);
        end
    end

    assign pc_o       = pc_q;
    assign pc_valid_o = started_q & ~stall_i;

endmodule

/* verilog/pipe_pkg.sv */
`include "frontend_macros.svh"

package pipe_pkg;

    import isa_pkg::*;

    // raw instruction as it leaves fetch
    typedef struct packed {
        logic [`FE_ADDR_WIDTH-1:0] pc;
        logic [31:0]               inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [`FE_ADDR_WIDTH-1:0] pc;
        logic [31:0]               inst;
        decode_info_t              decode_info;
        register_info_t            register_info;
    } inst_t;

endpackage
